// ==== sifhPkg.sv ====
/*
  Shared definitions for the two-pass histogram timing core
  Sizes, vector typedefs, window limits, register map
  and the frame state encoding
*/

package sifhPkg;

    // ******************************
    // Sizes
    // ******************************
    localparam int NP         = 8;
    localparam int NB         = 4;
    localparam int PIXELS     = 4;
    localparam int DATA_NUM   = 4;
    localparam int BINS_TOTAL = PIXELS * (1 << NB);
    // Cycles with sampleReady low between passes
    localparam int DRAIN_CYC  = 3;

    // Meaningful vector widths
    typedef logic [NP-1:0] timeStampT;
    typedef logic [NB-1:0] binAddrT;
    typedef logic [7:0]    binCountT;
    typedef logic [1:0]    pixelIdxT;
    typedef logic [7:0]    acqCountT;
    typedef logic [2:0]    wbAdrT;
    typedef logic [31:0]   wbDataT;

    // Window half width and highest legal window start
    localparam timeStampT HALF_WIN = 8'd8;
    localparam timeStampT WIN_MAX  = 8'd240;

    // ******************************
    // Register map, word addresses
    // ******************************
    localparam wbAdrT REG_CTRL    = 3'd0;
    localparam wbAdrT REG_STATUS  = 3'd1;
    localparam wbAdrT REG_RESULT0 = 3'd2;
    localparam wbAdrT REG_RESULT1 = 3'd3;
    localparam wbAdrT REG_RESULT2 = 3'd4;
    localparam wbAdrT REG_RESULT3 = 3'd5;

    // Frame sequencing
    typedef enum logic [2:0] {
        IDLE,
        COARSE,
        DRAIN,
        FINE,
        FINISH
    } frameStateT;

endpackage

// ==== sampleFilter.sv ====
/*
  Sample filter
  Turns a timestamp into a bin address for the active pass
  and drops fine samples outside the window
*/

`timescale 1ns/1ns

module sampleFilter (
    input  sifhPkg::timeStampT sample,
    input  logic               finePass,
    input  sifhPkg::timeStampT winStart,
    output sifhPkg::binAddrT   binAddr,
    output logic               binHit
);
    import sifhPkg::*;

    // Distance from window start, wraps when below it
    timeStampT offset;

    assign offset = sample - winStart;

    always_comb begin
        if (finePass) begin
            // Inside window only when at or above start and offset fits NB bits
            binHit  = (sample >= winStart) && (offset[NP-1:NB] == '0);
            binAddr = offset[NB-1:0];
        end else begin
            // Coarse pass keeps only the upper bits
            binHit  = 1'b1;
            binAddr = sample[NP-1 -: NB];
        end
    end

endmodule

// ==== histBuilder.sv ====
/*
  Histogram builder
  Frame FSM, sample/pixel/acquisition counters,
  bin memory with per-bin valid flags and count output
*/

`timescale 1ns/1ns

module histBuilder (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              startPulse,
    input  sifhPkg::acqCountT acqNum,
    input  logic              sampleValid,
    output logic              sampleReady,
    input  sifhPkg::binAddrT  binAddr,
    input  logic              binHit,
    output sifhPkg::pixelIdxT pixel,
    output logic              binWr,
    output sifhPkg::pixelIdxT binPixel,
    output sifhPkg::binAddrT  binAddrQ,
    output sifhPkg::binCountT binCount,
    output logic              passEnd,
    output logic              busy,
    output logic              done,
    output logic              finePass
);
    import sifhPkg::*;

    frameStateT                    state;
    logic [$clog2(DATA_NUM)-1:0]   sampleCnt;
    pixelIdxT                      pixelCnt;
    acqCountT                      acqCnt;
    logic [1:0]                    drainCnt;
    logic                          fineFlag;
    logic [BINS_TOTAL-1:0]         binValid;
    binCountT                      binMem [BINS_TOTAL];
    logic [$clog2(BINS_TOTAL)-1:0] memIdx;
    binCountT                      rdCount;
    binCountT                      newCount;
    logic                          accept;
    logic                          lastAcq;
    logic                          lastSample;

    assign sampleReady = (state == COARSE) || (state == FINE);
    assign busy        = (state == COARSE) || (state == DRAIN) || (state == FINE);
    assign done        = (state == FINISH);
    assign finePass    = fineFlag;
    assign pixel       = pixelCnt;
    assign passEnd     = (state == DRAIN) && (drainCnt == 2'(DRAIN_CYC - 1));

    assign accept     = sampleValid && sampleReady;
    // acqNum of zero behaves as one
    assign lastAcq    = (acqNum == '0) || (acqCnt == acqNum - 8'd1);
    assign lastSample = (sampleCnt == DATA_NUM - 1) && (pixelCnt == PIXELS - 1) && lastAcq;

    // ******************************
    // Bin read, stale bins read as 0
    // ******************************
    assign memIdx   = {pixelCnt, binAddr};
    assign rdCount  = binValid[memIdx] ? binMem[memIdx] : '0;
    assign newCount = (rdCount == 8'hFF) ? rdCount : rdCount + 8'd1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= IDLE;
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            drainCnt  <= '0;
            fineFlag  <= 1'b0;
            binValid  <= '0;
            binWr     <= 1'b0;
        end else begin
            binWr <= accept && binHit;
            case (state)
                IDLE, FINISH: begin
                    // New frame, histograms and counters start clean
                    if (startPulse) begin
                        state     <= COARSE;
                        sampleCnt <= '0;
                        pixelCnt  <= '0;
                        acqCnt    <= '0;
                        fineFlag  <= 1'b0;
                        binValid  <= '0;
                    end
                end
                COARSE, FINE: begin
                    if (accept) begin
                        if (binHit) begin
                            binValid[memIdx] <= 1'b1;
                        end
                        if (sampleCnt == DATA_NUM - 1) begin
                            sampleCnt <= '0;
                            pixelCnt  <= pixelCnt + 2'd1;
                            if (pixelCnt == PIXELS - 1) begin
                                acqCnt <= lastAcq ? '0 : acqCnt + 8'd1;
                            end
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                        if (lastSample) begin
                            state    <= DRAIN;
                            drainCnt <= '0;
                        end
                    end
                end
                DRAIN: begin
                    drainCnt <= drainCnt + 2'd1;
                    if (passEnd) begin
                        if (fineFlag) begin
                            state    <= FINISH;
                            fineFlag <= 1'b0;
                        end else begin
                            // Fine pass starts on an empty memory
                            state    <= FINE;
                            fineFlag <= 1'b1;
                            binValid <= '0;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Memory and count payload
    always_ff @(posedge clk) begin
        if (accept && binHit) begin
            binMem[memIdx] <= newCount;
            binCount       <= newCount;
            binPixel       <= pixelCnt;
            binAddrQ       <= binAddr;
        end
    end

endmodule

// ==== peakTracker.sv ====
/*
  Peak tracker
  Running maximum count and bin per pixel,
  coarse peak capture at the end of the coarse pass
*/

`timescale 1ns/1ns

module peakTracker (
    input  logic                                    clk,
    input  logic                                    combin_res,
    input  logic                                    clear,
    input  logic                                    binWr,
    input  sifhPkg::pixelIdxT                       binPixel,
    input  sifhPkg::binAddrT                        binAddrQ,
    input  sifhPkg::binCountT                       binCount,
    input  logic                                    passEnd,
    input  logic                                    finePass,
    output sifhPkg::binAddrT  [sifhPkg::PIXELS-1:0] coarsePeak,
    output sifhPkg::binAddrT  [sifhPkg::PIXELS-1:0] finePeak,
    output sifhPkg::binCountT [sifhPkg::PIXELS-1:0] finePeakCnt
);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            coarsePeak  <= '0;
            finePeak    <= '0;
            finePeakCnt <= '0;
        end else if (clear) begin
            // Frame start
            finePeak    <= '0;
            finePeakCnt <= '0;
        end else if (passEnd && !finePass) begin
            // Coarse peaks frozen, maxima restart for the fine pass
            coarsePeak  <= finePeak;
            finePeak    <= '0;
            finePeakCnt <= '0;
        end else if (binWr && (binCount > finePeakCnt[binPixel])) begin
            // Strictly greater so the earliest bin keeps a tie
            finePeakCnt[binPixel] <= binCount;
            finePeak[binPixel]    <= binAddrQ;
        end
    end

endmodule

// ==== windowCalc.sv ====
/*
  Window calculation
  Clamped fine window start per pixel from the coarse peak
  and the final per-pixel timestamp
*/

`timescale 1ns/1ns

module windowCalc (
    input  sifhPkg::binAddrT  [sifhPkg::PIXELS-1:0] coarsePeak,
    input  sifhPkg::binAddrT  [sifhPkg::PIXELS-1:0] finePeak,
    output sifhPkg::timeStampT [sifhPkg::PIXELS-1:0] winStartAll,
    output sifhPkg::timeStampT [sifhPkg::PIXELS-1:0] resultTs
);
    import sifhPkg::*;

    // ******************************
    // Window start per pixel
    // ******************************
    always_comb begin
        timeStampT scaled;
        for (int p = 0; p < PIXELS; p++) begin
            // Coarse bin back to timestamp units
            scaled = {coarsePeak[p], {(NP-NB){1'b0}}};
            if (scaled < HALF_WIN) begin
                winStartAll[p] = '0;
            end else if (scaled - HALF_WIN > WIN_MAX) begin
                winStartAll[p] = WIN_MAX;
            end else begin
                winStartAll[p] = scaled - HALF_WIN;
            end
        end
    end

    // Result is window start plus fine bin, never above 255
    always_comb begin
        for (int p = 0; p < PIXELS; p++) begin
            resultTs[p] = winStartAll[p] + {{(NP-NB){1'b0}}, finePeak[p]};
        end
    end

endmodule

// ==== sifhRegs.sv ====
/*
  Wishbone classic register block
  Control with start and acquisition count, status,
  per-pixel result read back
*/

`timescale 1ns/1ns

module sifhRegs (
    input  logic                                     clk,
    input  logic                                     combin_res,
    input  logic                                     wbCyc,
    input  logic                                     wbStb,
    input  logic                                     wbWe,
    input  sifhPkg::wbAdrT                           wbAdr,
    input  sifhPkg::wbDataT                          wbDatI,
    output sifhPkg::wbDataT                          wbDatO,
    output logic                                     wbAck,
    output logic                                     startPulse,
    output sifhPkg::acqCountT                        acqNum,
    input  logic                                     busy,
    input  logic                                     done,
    input  logic                                     finePass,
    input  sifhPkg::timeStampT [sifhPkg::PIXELS-1:0] resultTs,
    input  sifhPkg::binCountT  [sifhPkg::PIXELS-1:0] resultCnt
);
    import sifhPkg::*;

    logic     wbReq;
    logic     ctrlWr;
    pixelIdxT resIdx;
    wbDataT   rdData;

    // New request only while no ack is out
    assign wbReq  = wbCyc && wbStb && !wbAck;
    assign ctrlWr = wbReq && wbWe && (wbAdr == REG_CTRL);
    assign resIdx = pixelIdxT'(wbAdr - REG_RESULT0);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wbAck      <= 1'b0;
            startPulse <= 1'b0;
            acqNum     <= 8'd1;
        end else begin
            wbAck      <= wbReq;
            startPulse <= ctrlWr && wbDatI[0];
            if (ctrlWr) begin
                acqNum <= wbDatI[15:8];
            end
        end
    end

    // ******************************
    // Read mux
    // ******************************
    always_comb begin
        rdData = '0;
        case (wbAdr)
            REG_CTRL:   rdData[15:8] = acqNum;
            REG_STATUS: rdData[2:0]  = {finePass, done, busy};
            REG_RESULT0, REG_RESULT1, REG_RESULT2, REG_RESULT3: begin
                rdData[7:0]  = resultTs[resIdx];
                rdData[15:8] = resultCnt[resIdx];
            end
            default:    rdData = '0;
        endcase
    end

    // Held for the ack cycle
    always_ff @(posedge clk) begin
        if (wbReq) begin
            wbDatO <= rdData;
        end
    end

endmodule

// ==== sifhTop.sv ====
/*
  Top level
  Wishbone register block and the filter, histogram,
  peak and window processing chain
*/

`timescale 1ns/1ns

module sifhTop (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wbCyc,
    input  logic               wbStb,
    input  logic               wbWe,
    input  sifhPkg::wbAdrT     wbAdr,
    input  sifhPkg::wbDataT    wbDatI,
    output sifhPkg::wbDataT    wbDatO,
    output logic               wbAck,
    input  logic               sampleValid,
    input  sifhPkg::timeStampT sample,
    output logic               sampleReady
);
    import sifhPkg::*;

    logic                         startPulse;
    acqCountT                     acqNum;
    logic                         busy;
    logic                         done;
    logic                         finePass;
    logic                         clear;
    binAddrT                      binAddr;
    logic                         binHit;
    pixelIdxT                     pixel;
    logic                         binWr;
    pixelIdxT                     binPixel;
    binAddrT                      binAddrQ;
    binCountT                     binCount;
    logic                         passEnd;
    binAddrT   [PIXELS-1:0]       coarsePeak;
    binAddrT   [PIXELS-1:0]       finePeak;
    binCountT  [PIXELS-1:0]       finePeakCnt;
    timeStampT [PIXELS-1:0]       winStartAll;
    timeStampT [PIXELS-1:0]       resultTs;

    // Maxima restart only on a start that is taken
    assign clear = startPulse && !busy;

    sifhRegs u_regs (
        .clk(clk), .combin_res(combin_res),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatI(wbDatI), .wbDatO(wbDatO), .wbAck(wbAck),
        .startPulse(startPulse), .acqNum(acqNum),
        .busy(busy), .done(done), .finePass(finePass),
        .resultTs(resultTs), .resultCnt(finePeakCnt)
    );

    // Window of the pixel now streaming
    sampleFilter u_filter (
        .sample(sample), .finePass(finePass), .winStart(winStartAll[pixel]),
        .binAddr(binAddr), .binHit(binHit)
    );

    histBuilder u_hist (
        .clk(clk), .combin_res(combin_res),
        .startPulse(startPulse), .acqNum(acqNum),
        .sampleValid(sampleValid), .sampleReady(sampleReady),
        .binAddr(binAddr), .binHit(binHit), .pixel(pixel),
        .binWr(binWr), .binPixel(binPixel), .binAddrQ(binAddrQ), .binCount(binCount),
        .passEnd(passEnd), .busy(busy), .done(done), .finePass(finePass)
    );

    peakTracker u_peak (
        .clk(clk), .combin_res(combin_res), .clear(clear),
        .binWr(binWr), .binPixel(binPixel), .binAddrQ(binAddrQ), .binCount(binCount),
        .passEnd(passEnd), .finePass(finePass),
        .coarsePeak(coarsePeak), .finePeak(finePeak), .finePeakCnt(finePeakCnt)
    );

    windowCalc u_window (
        .coarsePeak(coarsePeak), .finePeak(finePeak),
        .winStartAll(winStartAll), .resultTs(resultTs)
    );

endmodule

// ==== sifhCheck_assert.sv ====
/*
  Bound checks on the top level
  Single-cycle Wishbone ack that follows a strobe,
  sampleReady gap between the coarse and fine passes
*/

`timescale 1ns/1ns

module sifhCheck (
    input logic clk,
    input logic combin_res,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck,
    input logic sampleReady,
    input logic finePass
);

    // Failures seen so far, read back by the testbench
    int failCount = 0;

    // ******************************
    // Wishbone handshake
    // ******************************
    ackOneCycle: assert property (@(posedge clk) disable iff (!combin_res)
        wbAck |=> !wbAck)
        else begin
            $error("wbAck stayed high for more than one cycle");
            failCount++;
        end

    // Ack only after cyc and stb were both seen
    ackAfterStrobe: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(wbAck) |-> $past(wbCyc && wbStb))
        else begin
            $error("wbAck rose without a preceding strobe");
            failCount++;
        end

    // Drain between passes, exactly 3 cycles without ready
    drainGap: assert property (@(posedge clk) disable iff (!combin_res)
        ($fell(sampleReady) && !finePass) |-> !sampleReady [*3] ##1 sampleReady)
        else begin
            $error("sampleReady gap after the coarse pass is not 3 cycles");
            failCount++;
        end

endmodule

bind sifhTop sifhCheck u_check (
    .clk(clk),
    .combin_res(combin_res),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbAck(wbAck),
    .sampleReady(sampleReady),
    .finePass(finePass)
);

// ==== sifhTb.sv ====
/*
  Testbench for the two-pass histogram timing core
  Clock, reset, Wishbone tasks, sample driver,
  reference model of both passes and result checks
*/

`timescale 1ns/1ns

module sifhTb;
    import sifhPkg::*;

    localparam int WAIT_LIMIT = 400;
    localparam int RUN_LIMIT  = 50000;
    localparam int FRAME_SAMP = PIXELS * DATA_NUM;
    localparam int MAX_SAMP   = 3 * FRAME_SAMP;

    logic      clk;
    logic      combin_res;
    logic      wbCyc;
    logic      wbStb;
    logic      wbWe;
    wbAdrT     wbAdr;
    wbDataT    wbDatI;
    wbDataT    wbDatO;
    logic      wbAck;
    logic      sampleValid;
    timeStampT sample;
    logic      sampleReady;

    integer    seed;
    int        errCount;
    int        testCount;
    int        acqN;
    logic      hung;
    logic      checkReq;
    // Stream order: acquisition, pixel, sample
    timeStampT coarseS [MAX_SAMP];
    timeStampT fineS   [MAX_SAMP];

    sifhTop u_dut (
        .clk(clk), .combin_res(combin_res),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatI(wbDatI), .wbDatO(wbDatO), .wbAck(wbAck),
        .sampleValid(sampleValid), .sample(sample), .sampleReady(sampleReady)
    );

    always #4 clk = ~clk;

    // Ends the run on a stuck wait or a runaway simulation
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (hung !== 1'b1 && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (hung !== 1'b1) begin
            $display("Simulation ran past its cycle limit");
        end
        $display("Testbench failed");
        $finish;
    end

    // ******************************
    // Wishbone master
    // ******************************
    task automatic wbWrite(input wbAdrT adr, input wbDataT data);
        int t;
        t = 0;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = 1'b1;
        wbAdr  = adr;
        wbDatI = data;
        @(negedge clk);
        while (!wbAck) begin
            t++;
            if (t == WAIT_LIMIT) begin
                $display("No Wishbone ack for a write to address %0d", adr);
                hung = 1'b1;
            end
            @(negedge clk);
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbRead(input wbAdrT adr, output wbDataT data);
        int t;
        t = 0;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = adr;
        @(negedge clk);
        while (!wbAck) begin
            t++;
            if (t == WAIT_LIMIT) begin
                $display("No Wishbone ack for a read from address %0d", adr);
                hung = 1'b1;
            end
            @(negedge clk);
        end
        // Read data valid for the whole ack cycle
        data  = wbDatO;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    // Offer one sample, accepted at the next rising edge
    task automatic sendSample(input timeStampT v);
        int t;
        t = 0;
        while (!sampleReady) begin
            sampleValid = 1'b0;
            t++;
            if (t == WAIT_LIMIT) begin
                $display("sampleReady never came back high");
                hung = 1'b1;
            end
            @(negedge clk);
        end
        sampleValid = 1'b1;
        sample      = v;
        @(negedge clk);
    endtask

    // Poll status until done
    task automatic waitDone();
        wbDataT st;
        int     t;
        t = 0;
        wbRead(REG_STATUS, st);
        while (!st[1]) begin
            t++;
            if (t == WAIT_LIMIT) begin
                $display("Frame never reported done");
                hung = 1'b1;
            end
            wbRead(REG_STATUS, st);
        end
    endtask

    // ******************************
    // Reference model
    // ******************************
    function automatic int windowStart(int p);
        int hist [16];
        int maxCnt;
        int maxBin;
        int b;
        int ws;
        for (int i = 0; i < 16; i++) begin
            hist[i] = 0;
        end
        maxCnt = 0;
        maxBin = 0;
        for (int a = 0; a < acqN; a++) begin
            for (int s = 0; s < DATA_NUM; s++) begin
                b = int'(coarseS[a * FRAME_SAMP + p * DATA_NUM + s]) / 16;
                if (hist[b] < 255) begin
                    hist[b]++;
                end
                // Ties keep the bin that got there first
                if (hist[b] > maxCnt) begin
                    maxCnt = hist[b];
                    maxBin = b;
                end
            end
        end
        ws = maxBin * 16 - int'(HALF_WIN);
        if (ws < 0) begin
            ws = 0;
        end
        if (ws > 240) begin
            ws = 240;
        end
        return ws;
    endfunction

    // Fine count in 15:8, timestamp in 7:0
    function automatic logic [15:0] refResult(int p);
        int hist [16];
        int ws;
        int off;
        int maxCnt;
        int maxBin;
        for (int i = 0; i < 16; i++) begin
            hist[i] = 0;
        end
        maxCnt = 0;
        maxBin = 0;
        ws     = windowStart(p);
        for (int a = 0; a < acqN; a++) begin
            for (int s = 0; s < DATA_NUM; s++) begin
                off = int'(fineS[a * FRAME_SAMP + p * DATA_NUM + s]) - ws;
                // Outside the 16-wide window, dropped
                if (off >= 0 && off < 16) begin
                    if (hist[off] < 255) begin
                        hist[off]++;
                    end
                    if (hist[off] > maxCnt) begin
                        maxCnt = hist[off];
                        maxBin = off;
                    end
                end
            end
        end
        return {8'(maxCnt), 8'(ws + maxBin)};
    endfunction

    // Random timestamp around a center
    function automatic timeStampT nearby(int center, int spread);
        int v;
        v = center + ($random(seed) % spread);
        if (v < 0) begin
            v = 0;
        end
        if (v > 255) begin
            v = 255;
        end
        return timeStampT'(v);
    endfunction

    task automatic makeFrame(input int acq, input int c0, input int c1,
                             input int c2, input int c3, input int spread);
        int c [4];
        int idx;
        c[0] = c0;
        c[1] = c1;
        c[2] = c2;
        c[3] = c3;
        acqN = acq;
        for (int a = 0; a < acq; a++) begin
            for (int p = 0; p < PIXELS; p++) begin
                for (int s = 0; s < DATA_NUM; s++) begin
                    idx          = a * FRAME_SAMP + p * DATA_NUM + s;
                    coarseS[idx] = nearby(c[p], spread);
                    fineS[idx]   = nearby(c[p], spread);
                end
            end
        end
    endtask

    // Start, stream both passes, wait for done, then compare
    task automatic runFrame();
        int t;
        wbWrite(REG_CTRL, (32'(acqN) << 8) | 32'h1);
        for (int i = 0; i < acqN * FRAME_SAMP; i++) begin
            sendSample(coarseS[i]);
        end
        for (int i = 0; i < acqN * FRAME_SAMP; i++) begin
            sendSample(fineS[i]);
        end
        sampleValid = 1'b0;
        waitDone();
        checkReq = 1'b1;
        t = 0;
        while (checkReq) begin
            t++;
            if (t == WAIT_LIMIT) begin
                $display("Result comparison never finished");
                hung = 1'b1;
            end
            @(negedge clk);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount++;
        if (errCount == errBefore) begin
            $display("Test %0d %s: ok", testCount, name);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", testCount, name,
                     errCount - errBefore);
        end
    endtask

    // ******************************
    // Result comparison
    // ******************************
    initial begin : compareProc
        wbDataT      got;
        logic [15:0] exp;
        forever begin
            @(negedge clk);
            if (checkReq) begin
                for (int p = 0; p < PIXELS; p++) begin
                    wbRead(wbAdrT'(REG_RESULT0 + p), got);
                    exp = refResult(p);
                    if (got !== {16'h0, exp}) begin
                        $display("ERROR at %0t ns: pixel %0d result %h, expected %h",
                                 $time, p, got, exp);
                        errCount++;
                    end
                end
                checkReq = 1'b0;
            end
        end
    end

    // ******************************
    // Test sequence
    // ******************************
    initial begin : mainProc
        wbDataT d;
        int     errBefore;
        int     p;
        int     s;
        int     ws;
        clk         = 1'b0;
        combin_res  = 1'b0;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAdr       = '0;
        wbDatI      = '0;
        sampleValid = 1'b0;
        sample      = '0;
        seed        = 73;
        errCount    = 0;
        testCount   = 0;
        acqN        = 1;
        hung        = 1'b0;
        checkReq    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;

        // Idle state after reset
        errBefore = errCount;
        if (sampleReady !== 1'b0) begin
            $display("ERROR at %0t ns: sampleReady high after reset", $time);
            errCount++;
        end
        wbRead(REG_STATUS, d);
        if (d !== 32'h0) begin
            $display("ERROR at %0t ns: STATUS %h, expected 0", $time, d);
            errCount++;
        end
        wbRead(REG_CTRL, d);
        if (d !== 32'h100) begin
            $display("ERROR at %0t ns: CTRL %h, expected 00000100", $time, d);
            errCount++;
        end
        reportTest("reset values", errBefore);

        // Peaks one bin above each window start
        errBefore = errCount;
        makeFrame(1, 34, 98, 146, 210, 3);
        runFrame();
        reportTest("centered peaks", errBefore);

        // Low clamp at 0, top bin at 232
        errBefore = errCount;
        makeFrame(1, 1, 244, 3, 241, 3);
        runFrame();
        reportTest("window clamps", errBefore);

        // Higher bin reaches each count first in both passes
        errBefore = errCount;
        acqN = 3;
        for (int i = 0; i < MAX_SAMP; i++) begin
            p          = (i / DATA_NUM) % PIXELS;
            s          = i % DATA_NUM;
            coarseS[i] = (s % 2 == 0) ? timeStampT'((9 + p) * 16 + 3)
                                      : timeStampT'((3 + p) * 16 + 5);
        end
        for (int i = 0; i < MAX_SAMP; i++) begin
            p        = (i / DATA_NUM) % PIXELS;
            s        = i % DATA_NUM;
            ws       = windowStart(p);
            fineS[i] = (s % 2 == 0) ? timeStampT'(ws + 12) : timeStampT'(ws + 4);
        end
        runFrame();
        reportTest("tied bins", errBefore);

        // Pixels 0 and 1 all outside, pixels 2 and 3 half outside
        errBefore = errCount;
        makeFrame(1, 82, 114, 162, 194, 3);
        for (int i = 0; i < FRAME_SAMP; i++) begin
            p  = i / DATA_NUM;
            s  = i % DATA_NUM;
            ws = windowStart(p);
            if (p < 2 || s % 2 == 1) begin
                fineS[i] = timeStampT'(ws + 16 + s);
            end else begin
                fineS[i] = timeStampT'(ws + 7);
            end
        end
        runFrame();
        reportTest("out of window samples", errBefore);

        // First frame leaves bin 7 at count 4 in every pixel
        errBefore = errCount;
        acqN = 1;
        for (int i = 0; i < FRAME_SAMP; i++) begin
            p          = i / DATA_NUM;
            coarseS[i] = timeStampT'((2 + 4 * p) * 16 + 5);
        end
        for (int i = 0; i < FRAME_SAMP; i++) begin
            p        = i / DATA_NUM;
            fineS[i] = timeStampT'(windowStart(p) + 7);
        end
        runFrame();
        // Bins 11 and 7 tie, leftover counts in bin 7 would win
        for (int i = 0; i < FRAME_SAMP; i++) begin
            s          = i % DATA_NUM;
            coarseS[i] = (s % 2 == 0) ? timeStampT'(11 * 16 + 3)
                                      : timeStampT'(7 * 16 + 9);
        end
        for (int i = 0; i < FRAME_SAMP; i++) begin
            p        = i / DATA_NUM;
            fineS[i] = timeStampT'(windowStart(p) + 7);
        end
        runFrame();
        reportTest("second frame", errBefore);

        $display("Summary: %0d tests, %0d errors, %0d assertion failures",
                 testCount, errCount, u_dut.u_check.failCount);
        errCount += u_dut.u_check.failCount;
        if (errCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
sifhPkg.sv
sampleFilter.sv
histBuilder.sv
peakTracker.sv
windowCalc.sv
sifhRegs.sv
sifhTop.sv
sifhCheck_assert.sv
sifhTb.sv
